// ==== Makefile ====
# Verilator build and run of the execute-slice testbench

SIM := obj_dir/Vtb_mips_exec

.PHONY: run clean

run: $(SIM)
	./$(SIM)

# Rebuilt only when a source, header or the file list changes
$(SIM): mips_exec.f $(wildcard *.sv *.svh)
	verilator --binary -j 0 --top-module tb_mips_exec -f mips_exec.f

clean:
	rm -rf obj_dir

// ==== mips_alu.sv ====
`default_nettype none

`include "mips_exec_cfg.svh"

module mips_alu
    import mips_exec_pkg::*;
(
    input  wire             i_clk,
    input  wire             i_rst_n,
    // Decoded controls
    input  wire             i_valid,
    input  wire alu_op_e    i_alu_op,
    input  wire             i_use_imm,
    input  wire word_t      i_imm,
    input  wire shamt_t     i_shamt,
    input  wire reg_addr_t  i_dest,
    input  wire             i_wr_en,
    input  wire             i_illegal,
    // Operands from the register file
    input  wire word_t      i_rs_data,
    input  wire word_t      i_rt_data,
    // Result
    output logic            o_valid,
    output word_t           o_result,
    output reg_addr_t       o_dest,
    output logic            o_illegal,
    // Write-back to the register file
    output logic            o_wb_en,
    output reg_addr_t       o_wb_addr,
    output word_t           o_wb_data
);

    localparam int HALF = `MIPS_XLEN / 2;

    word_t      op_a;
    word_t      op_b;
    word_t      alu_out;
    word_t      result_q;
    reg_addr_t  dest_q;
    logic       valid_q;
    logic       illegal_q;
    logic       wr_en_q;

    // Operand B is either rt or the extended immediate
    assign op_a = i_rs_data;
    assign op_b = i_use_imm ? i_imm : i_rt_data;

    //////////////////////////////////////////////////////////////////////
    // Compute
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (i_alu_op)
            ALU_ADD:  alu_out = op_a + op_b;
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_AND:  alu_out = op_a & op_b;
            ALU_OR:   alu_out = op_a | op_b;
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_NOR:  alu_out = ~(op_a | op_b);
            ALU_SLT:  alu_out = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_out = word_t'(op_a < op_b);
            // Shifts act on rt, rs is ignored
            ALU_SLL:  alu_out = i_rt_data << i_shamt;
            ALU_SRL:  alu_out = i_rt_data >> i_shamt;
            ALU_SRA:  alu_out = word_t'($signed(i_rt_data) >>> i_shamt);
            // Low half of the immediate into the upper half
            ALU_LUI:  alu_out = i_imm << HALF;
            default:  alu_out = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Result register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            valid_q   <= 1'b0;
            illegal_q <= 1'b0;
            wr_en_q   <= 1'b0;
        end
        else
        begin
            valid_q   <= i_valid;
            illegal_q <= i_valid && i_illegal;
            wr_en_q   <= i_valid && i_wr_en;
        end
    end

    // Illegal instructions report a zero result
    always_ff @(posedge i_clk)
    begin
        if (i_valid)
        begin
            result_q <= i_illegal ? '0 : alu_out;
            dest_q   <= i_dest;
        end
    end

    assign o_valid   = valid_q;
    assign o_result  = result_q;
    assign o_dest    = dest_q;
    assign o_illegal = illegal_q;

    // Same registered fields feed the write port
    assign o_wb_en   = valid_q && wr_en_q;
    assign o_wb_addr = dest_q;
    assign o_wb_data = result_q;

endmodule

`default_nettype wire

// ==== mips_decoder.sv ====
`default_nettype none

`include "mips_exec_cfg.svh"

module mips_decoder
    import mips_exec_pkg::*;
(
    input  wire             i_clk,
    input  wire             i_rst_n,
    input  wire             i_valid,
    input  wire instr_t     i_instr,
    // Registered controls for the ALU stage
    output logic            o_valid,
    output alu_op_e         o_alu_op,
    output logic            o_use_imm,
    output word_t           o_imm,
    output shamt_t          o_shamt,
    output reg_addr_t       o_dest,
    output logic            o_wr_en,
    output logic            o_illegal
);

    localparam int IMM_W = `MIPS_IMM_HI - `MIPS_IMM_LO + 1;

    // Raw instruction fields
    opcode_t            op;
    funct_t             fn;
    shamt_t             sh;
    reg_addr_t          rt;
    reg_addr_t          rd;
    logic [IMM_W-1:0]   imm_raw;
    word_t              imm_sext;
    word_t              imm_zext;

    // Next-state decode
    alu_op_e            op_d;
    logic               use_imm_d;
    word_t              imm_d;
    reg_addr_t          dest_d;
    logic               illegal_d;

    assign op      = i_instr[`MIPS_OP_HI:`MIPS_OP_LO];
    assign fn      = i_instr[`MIPS_FUNCT_HI:`MIPS_FUNCT_LO];
    assign sh      = i_instr[`MIPS_SHAMT_HI:`MIPS_SHAMT_LO];
    assign rt      = i_instr[`MIPS_RT_HI:`MIPS_RT_LO];
    assign rd      = i_instr[`MIPS_RD_HI:`MIPS_RD_LO];
    assign imm_raw = i_instr[`MIPS_IMM_HI:`MIPS_IMM_LO];

    // Both extensions, picked per opcode below
    assign imm_sext = {{(`MIPS_XLEN-IMM_W){imm_raw[IMM_W-1]}}, imm_raw};
    assign imm_zext = {{(`MIPS_XLEN-IMM_W){1'b0}}, imm_raw};

    //////////////////////////////////////////////////////////////////////
    // Opcode and funct decode
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        op_d      = ALU_ADD;
        use_imm_d = 1'b0;
        imm_d     = '0;
        dest_d    = rd;
        illegal_d = 1'b0;
        case (op)
            OP_RTYPE:
            begin
                case (fn)
                    FN_SLL:  op_d = ALU_SLL;
                    FN_SRL:  op_d = ALU_SRL;
                    FN_SRA:  op_d = ALU_SRA;
                    FN_ADDU: op_d = ALU_ADD;
                    FN_SUBU: op_d = ALU_SUB;
                    FN_AND:  op_d = ALU_AND;
                    FN_OR:   op_d = ALU_OR;
                    FN_XOR:  op_d = ALU_XOR;
                    FN_NOR:  op_d = ALU_NOR;
                    FN_SLT:  op_d = ALU_SLT;
                    FN_SLTU: op_d = ALU_SLTU;
                    default: illegal_d = 1'b1;
                endcase
            end
            // Signed immediates, SLTIU compares the sign-extended value unsigned
            OP_ADDIU: begin op_d = ALU_ADD;  imm_d = imm_sext; end
            OP_SLTI:  begin op_d = ALU_SLT;  imm_d = imm_sext; end
            OP_SLTIU: begin op_d = ALU_SLTU; imm_d = imm_sext; end
            // Logic immediates are zero-extended
            OP_ANDI:  begin op_d = ALU_AND;  imm_d = imm_zext; end
            OP_ORI:   begin op_d = ALU_OR;   imm_d = imm_zext; end
            OP_XORI:  begin op_d = ALU_XOR;  imm_d = imm_zext; end
            // Raw 16 bits, ALU moves them up
            OP_LUI:   begin op_d = ALU_LUI;  imm_d = imm_zext; end
            default:  illegal_d = 1'b1;
        endcase
        // I-type writes rt and takes the immediate as operand B
        if (op != OP_RTYPE)
        begin
            use_imm_d = 1'b1;
            dest_d    = rt;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output registers
    //////////////////////////////////////////////////////////////////////

    // Control, qualified by the strobe
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_valid   <= 1'b0;
            o_wr_en   <= 1'b0;
            o_illegal <= 1'b0;
        end
        else
        begin
            o_valid   <= i_valid;
            o_wr_en   <= i_valid && !illegal_d;
            o_illegal <= i_valid && illegal_d;
        end
    end

    // Payload, only loaded for a real instruction
    always_ff @(posedge i_clk)
    begin
        if (i_valid)
        begin
            o_alu_op  <= op_d;
            o_use_imm <= use_imm_d;
            o_imm     <= imm_d;
            o_shamt   <= sh;
            o_dest    <= dest_d;
        end
    end

endmodule

`default_nettype wire

// ==== mips_exec.f ====
+incdir+.
mips_exec_pkg.sv
mips_regfile.sv
mips_decoder.sv
mips_alu.sv
mips_exec_top.sv
tb_mips_exec.sv

// ==== mips_exec_cfg.svh ====
`ifndef MIPS_EXEC_CFG_SVH
`define MIPS_EXEC_CFG_SVH

// Datapath width
`define MIPS_XLEN       32

// Register file geometry
`define MIPS_RADDR_W    5
`define MIPS_NREGS      32

// Opcode field
`define MIPS_OP_HI      31
`define MIPS_OP_LO      26
// Source and target register fields
`define MIPS_RS_HI      25
`define MIPS_RS_LO      21
`define MIPS_RT_HI      20
`define MIPS_RT_LO      16
// R-type destination, shift amount and funct
`define MIPS_RD_HI      15
`define MIPS_RD_LO      11
`define MIPS_SHAMT_HI   10
`define MIPS_SHAMT_LO   6
`define MIPS_FUNCT_HI   5
`define MIPS_FUNCT_LO   0
// I-type immediate, overlaps rd/shamt/funct
`define MIPS_IMM_HI     15
`define MIPS_IMM_LO     0

`endif

// ==== mips_exec_pkg.sv ====
`default_nettype none

`include "mips_exec_cfg.svh"

package mips_exec_pkg;

    //////////////////////////////////////////////////////////////////////
    // Field types
    //////////////////////////////////////////////////////////////////////

    typedef logic [`MIPS_XLEN-1:0]                     word_t;
    typedef logic [`MIPS_XLEN-1:0]                     instr_t;
    typedef logic [`MIPS_RADDR_W-1:0]                  reg_addr_t;
    typedef logic [`MIPS_OP_HI-`MIPS_OP_LO:0]          opcode_t;
    typedef logic [`MIPS_FUNCT_HI-`MIPS_FUNCT_LO:0]    funct_t;
    typedef logic [`MIPS_SHAMT_HI-`MIPS_SHAMT_LO:0]    shamt_t;

    // Operations the execute stage knows
    typedef enum logic [3:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    //////////////////////////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////////////////////////

    // Primary opcodes, 0 selects the funct table
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_SLTI  = 6'h0a;
    localparam opcode_t OP_SLTIU = 6'h0b;
    localparam opcode_t OP_ANDI  = 6'h0c;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_XORI  = 6'h0e;
    localparam opcode_t OP_LUI   = 6'h0f;

    // R-type funct codes
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_SRA  = 6'h03;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;
    localparam funct_t FN_SLT  = 6'h2a;
    localparam funct_t FN_SLTU = 6'h2b;

endpackage

`default_nettype wire

// ==== mips_exec_top.sv ====
`default_nettype none

`include "mips_exec_cfg.svh"

module mips_exec_top
    import mips_exec_pkg::*;
(
    input  wire             i_clk,
    input  wire             i_rst_n,
    input  wire             i_instr_valid,
    input  wire instr_t     i_instr,
    output logic            o_result_valid,
    output word_t           o_result,
    output reg_addr_t       o_dest,
    output logic            o_illegal
);

    // Operand path
    word_t      rs_data;
    word_t      rt_data;

    // Decoder to ALU
    logic       dec_valid;
    alu_op_e    dec_alu_op;
    logic       dec_use_imm;
    word_t      dec_imm;
    shamt_t     dec_shamt;
    reg_addr_t  dec_dest;
    logic       dec_wr_en;
    logic       dec_illegal;

    // Write-back loop
    logic       wb_en;
    reg_addr_t  wb_addr;
    word_t      wb_data;

    //////////////////////////////////////////////////////////////////////
    // Cycle 1, operand read and decode in parallel
    //////////////////////////////////////////////////////////////////////

    mips_regfile regfile_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rs_addr  (i_instr[`MIPS_RS_HI:`MIPS_RS_LO]),
        .i_rt_addr  (i_instr[`MIPS_RT_HI:`MIPS_RT_LO]),
        .i_wr_en    (wb_en),
        .i_wr_addr  (wb_addr),
        .i_wr_data  (wb_data),
        .o_rs_data  (rs_data),
        .o_rt_data  (rt_data)
    );

    mips_decoder decoder_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (i_instr_valid),
        .i_instr    (i_instr),
        .o_valid    (dec_valid),
        .o_alu_op   (dec_alu_op),
        .o_use_imm  (dec_use_imm),
        .o_imm      (dec_imm),
        .o_shamt    (dec_shamt),
        .o_dest     (dec_dest),
        .o_wr_en    (dec_wr_en),
        .o_illegal  (dec_illegal)
    );

    //////////////////////////////////////////////////////////////////////
    // Cycle 2, execute and write back
    //////////////////////////////////////////////////////////////////////

    mips_alu alu_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (dec_valid),
        .i_alu_op   (dec_alu_op),
        .i_use_imm  (dec_use_imm),
        .i_imm      (dec_imm),
        .i_shamt    (dec_shamt),
        .i_dest     (dec_dest),
        .i_wr_en    (dec_wr_en),
        .i_illegal  (dec_illegal),
        .i_rs_data  (rs_data),
        .i_rt_data  (rt_data),
        .o_valid    (o_result_valid),
        .o_result   (o_result),
        .o_dest     (o_dest),
        .o_illegal  (o_illegal),
        .o_wb_en    (wb_en),
        .o_wb_addr  (wb_addr),
        .o_wb_data  (wb_data)
    );

endmodule

`default_nettype wire

// ==== mips_regfile.sv ====
`default_nettype none

`include "mips_exec_cfg.svh"

module mips_regfile
    import mips_exec_pkg::*;
(
    input  wire             i_clk,
    input  wire             i_rst_n,
    // Read addresses sampled with the instruction strobe
    input  wire reg_addr_t  i_rs_addr,
    input  wire reg_addr_t  i_rt_addr,
    // Write-back port
    input  wire             i_wr_en,
    input  wire reg_addr_t  i_wr_addr,
    input  wire word_t      i_wr_data,
    // Operands for the cycle after the strobe
    output word_t           o_rs_data,
    output word_t           o_rt_data
);

    //////////////////////////////////////////////////////////////////////
    // Storage
    //////////////////////////////////////////////////////////////////////

    word_t      regs [`MIPS_NREGS];
    reg_addr_t  rs_q;
    reg_addr_t  rt_q;
    logic       wr_ok;

    // Writes to register 0 are dropped here
    assign wr_ok = i_wr_en && (i_wr_addr != '0);

    // Whole array cleared on reset
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < `MIPS_NREGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_ok)
        begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////////////////////////

    // Addresses captured at the strobe edge
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            rs_q <= '0;
            rt_q <= '0;
        end
        else
        begin
            rs_q <= i_rs_addr;
            rt_q <= i_rt_addr;
        end
    end

    // Data resolved during the operand cycle
    // A write landing at the end of this cycle wins over the array
    // This is what lets instruction n+1 consume the result of n
    function automatic word_t read_port(input reg_addr_t addr);
        word_t data;
        if (wr_ok && (i_wr_addr == addr))
        begin
            data = i_wr_data;
        end
        else
        begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb
    begin
        o_rs_data = read_port(rs_q);
        o_rt_data = read_port(rt_q);
    end

endmodule

`default_nettype wire

// ==== tb_mips_exec.sv ====
`default_nettype none

`include "mips_exec_cfg.svh"

module tb_mips_exec
    import mips_exec_pkg::*;
();

    localparam int RESET_CYCLES    = 16;
    // Directed section lengths in issue order
    // Reset sweep, register load, R ops, I ops, chain, register 0, illegal, first edge
    localparam int DIRECTED_CYCLES = 32 + 62 + 44 + 28 + 6 + 9 + 6 + 1;
    localparam int N_RANDOM        = 800;
    localparam int MAX_GAP         = 3;
    localparam int DRAIN_CYCLES    = 8;
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES
                                   + N_RANDOM * (MAX_GAP + 1) + DRAIN_CYCLES + 50;

    logic       clk;
    logic       rst_n;
    logic       instr_valid;
    instr_t     instr;
    logic       result_valid;
    word_t      result;
    reg_addr_t  dest;
    logic       illegal;

    // Architectural register model updated in issue order
    word_t      model_regs [`MIPS_NREGS];
    // Expected responses with the oldest first
    word_t      exp_result_q [$];
    reg_addr_t  exp_dest_q [$];
    logic       exp_illegal_q [$];
    int         exp_edge_q [$];
    // Rising edges seen so far
    int         cycle = 0;
    logic [31:0] rng = 32'h8ca2;

    // Operand tables for the directed and random sections
    funct_t  r_functs [11] = '{FN_SLL, FN_SRL, FN_SRA, FN_ADDU, FN_SUBU, FN_AND,
                               FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
    opcode_t imm_ops [7]   = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI,
                               OP_XORI, OP_LUI};
    word_t   seed_vals [4] = '{32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h0000_0001};
    logic [15:0] imm_vals [4] = '{16'h8000, 16'h7fff, 16'hffff, 16'h0001};
    int      shifts [4]    = '{0, 1, 31, 13};

    mips_exec_top dut_i (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_instr_valid  (instr_valid),
        .i_instr        (instr),
        .o_result_valid (result_valid),
        .o_result       (result),
        .o_dest         (dest),
        .o_illegal      (illegal)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic instr_t make_rtype(input funct_t fn, input int rs, input int rt,
                                          input int rd, input int sh);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic instr_t make_itype(input opcode_t op, input int rs, input int rt,
                                          input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // Expected result straight from the instruction set rules
    function automatic word_t ref_exec(input instr_t ins, output reg_addr_t rd_exp,
                                       output logic bad);
        opcode_t op;
        funct_t  fn;
        shamt_t  sh;
        word_t   rs_val;
        word_t   rt_val;
        word_t   imm_s;
        word_t   imm_z;
        word_t   r;
        logic    lt_s;
        op     = ins[`MIPS_OP_HI:`MIPS_OP_LO];
        fn     = ins[`MIPS_FUNCT_HI:`MIPS_FUNCT_LO];
        sh     = ins[`MIPS_SHAMT_HI:`MIPS_SHAMT_LO];
        rs_val = model_regs[ins[`MIPS_RS_HI:`MIPS_RS_LO]];
        rt_val = model_regs[ins[`MIPS_RT_HI:`MIPS_RT_LO]];
        imm_s  = {{16{ins[15]}}, ins[15:0]};
        imm_z  = {16'h0000, ins[15:0]};
        r      = '0;
        bad    = 1'b0;
        rd_exp = ins[`MIPS_RT_HI:`MIPS_RT_LO];
        if (op == OP_RTYPE)
        begin
            rd_exp = ins[`MIPS_RD_HI:`MIPS_RD_LO];
            // Signed less-than from the sign bits first
            lt_s = (rs_val[31] != rt_val[31]) ? rs_val[31] : (rs_val < rt_val);
            case (fn)
                FN_ADDU: r = rs_val + rt_val;
                FN_SUBU: r = rs_val + ~rt_val + 32'd1;
                FN_AND:  r = rs_val & rt_val;
                FN_OR:   r = rs_val | rt_val;
                FN_XOR:  r = rs_val ^ rt_val;
                FN_NOR:  r = ~rs_val & ~rt_val;
                FN_SLT:  r = {31'b0, lt_s};
                FN_SLTU: r = {31'b0, rs_val < rt_val};
                FN_SLL:  r = rt_val << sh;
                FN_SRL:  r = rt_val >> sh;
                // Logical shift with the vacated top bits filled by the sign
                FN_SRA:  r = (rt_val >> sh) | (rt_val[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
                default: bad = 1'b1;
            endcase
        end
        else
        begin
            lt_s = (rs_val[31] != imm_s[31]) ? rs_val[31] : (rs_val < imm_s);
            case (op)
                OP_ADDIU: r = rs_val + imm_s;
                OP_SLTI:  r = {31'b0, lt_s};
                OP_SLTIU: r = {31'b0, rs_val < imm_s};
                OP_ANDI:  r = rs_val & imm_z;
                OP_ORI:   r = rs_val | imm_z;
                OP_XORI:  r = rs_val ^ imm_z;
                OP_LUI:   r = {ins[15:0], 16'h0000};
                default:  bad = 1'b1;
            endcase
        end
        return r;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("ERROR: %s expected 0x%h actual 0x%h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    // Runs from one falling edge to the next
    task automatic issue(input instr_t ins);
        word_t     r;
        reg_addr_t rd_exp;
        logic      bad;
        r = ref_exec(ins, rd_exp, bad);
        if (!bad && (rd_exp != '0))
        begin
            model_regs[rd_exp] = r;
        end
        exp_result_q.push_back(bad ? '0 : r);
        exp_dest_q.push_back(rd_exp);
        exp_illegal_q.push_back(bad);
        // Strobe sampled at edge cycle+1 and the result two edges later
        exp_edge_q.push_back(cycle + 3);
        instr_valid = 1'b1;
        instr       = ins;
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Compare process
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        word_t     exp_r;
        reg_addr_t exp_d;
        logic      exp_i;
        int        exp_e;
        cycle = cycle + 1;
        if (cycle > TIMEOUT_CYCLES)
        begin
            abort_run($sformatf("Timeout after %0d cycles", cycle));
        end
        else if (result_valid)
        begin
            if (exp_result_q.size() == 0)
            begin
                abort_run("Result strobe seen with no instruction outstanding");
            end
            else
            begin
                exp_r = exp_result_q.pop_front();
                exp_d = exp_dest_q.pop_front();
                exp_i = exp_illegal_q.pop_front();
                exp_e = exp_edge_q.pop_front();
                if (exp_e != cycle)
                begin
                    abort_run($sformatf("Result at edge %0d, expected at edge %0d",
                                        cycle, exp_e));
                end
                else
                begin
                    check_value("o_result", exp_r, result);
                    check_value("o_dest", 32'(exp_d), 32'(dest));
                    check_value("o_illegal", 32'(exp_i), 32'(illegal));
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        word_t       v;
        logic [31:0] sel;
        logic [31:0] fields;
        instr_t      ins;
        int          k;
        int          gap;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        for (int i = 0; i < `MIPS_NREGS; i++)
        begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Every register reads zero after reset
        for (int i = 0; i < 32; i++)
        begin
            issue(make_rtype(FN_ADDU, i, i, 0, 0));
        end

        // Each ORI consumes the preceding LUI through the bypass
        for (int i = 1; i < 32; i++)
        begin
            rng = xorshift32(rng);
            if (i <= 4)
            begin
                v = seed_vals[i-1];
            end
            else
            begin
                v = rng;
            end
            issue(make_itype(OP_LUI, 0, i, v[31:16]));
            issue(make_itype(OP_ORI, i, i, v[15:0]));
        end

        // Each R op over sign corners and shift extremes
        for (int f = 0; f < 11; f++)
        begin
            for (int p = 0; p < 4; p++)
            begin
                issue(make_rtype(r_functs[f], 1 + p, 1 + ((p + 1) % 4), 8 + p, shifts[p]));
            end
        end

        // Each I op with both extension corners
        for (int f = 0; f < 7; f++)
        begin
            for (int p = 0; p < 4; p++)
            begin
                issue(make_itype(imm_ops[f], 1 + p, 12 + p, imm_vals[p]));
            end
        end

        // Dependent chain at full rate
        issue(make_itype(OP_ADDIU, 0, 24, 16'h0005));
        issue(make_rtype(FN_ADDU, 24, 24, 25, 0));
        issue(make_rtype(FN_SUBU, 24, 25, 26, 0));
        issue(make_rtype(FN_SRA, 0, 26, 27, 1));
        issue(make_rtype(FN_XOR, 27, 25, 28, 0));
        issue(make_rtype(FN_SLTU, 28, 27, 29, 0));

        // Register 0 keeps no value in the array or on the bypass
        issue(make_itype(OP_ADDIU, 0, 0, 16'h1234));
        issue(make_rtype(FN_ADDU, 0, 0, 22, 0));
        repeat (2) @(negedge clk);
        issue(make_itype(OP_ORI, 3, 0, 16'hffff));
        repeat (3) @(negedge clk);
        issue(make_rtype(FN_OR, 0, 0, 23, 0));

        // Unknown opcodes and functs followed by reads of their targets
        issue(make_itype(6'h23, 1, 5, 16'h00ff));
        issue(make_itype(6'h3f, 2, 6, 16'hffff));
        issue(make_rtype(6'h18, 3, 4, 7, 0));
        issue(make_rtype(6'h01, 3, 4, 5, 2));
        issue(make_rtype(FN_OR, 5, 0, 20, 0));
        issue(make_rtype(FN_OR, 6, 7, 21, 0));

        // Random mix with some raw words for illegal encodings
        for (int n = 0; n < N_RANDOM; n++)
        begin
            rng    = xorshift32(rng);
            sel    = rng;
            rng    = xorshift32(rng);
            fields = rng;
            if (sel[2:0] == 3'd0)
            begin
                ins = fields;
            end
            else if (sel[3])
            begin
                k   = int'(sel[7:4]) % 11;
                ins = make_rtype(r_functs[k], int'(fields[4:0]), int'(fields[9:5]),
                                 int'(fields[14:10]), int'(fields[19:15]));
            end
            else
            begin
                k   = int'(sel[7:4]) % 7;
                ins = make_itype(imm_ops[k], int'(fields[4:0]), int'(fields[9:5]),
                                 fields[31:16]);
            end
            issue(ins);
            // Mostly bursts with short idle gaps now and then
            gap = sel[8] ? int'(sel[10:9]) : 0;
            repeat (gap) @(negedge clk);
        end

        repeat (DRAIN_CYCLES) @(negedge clk);
        if (exp_result_q.size() != 0)
        begin
            abort_run($sformatf("%0d expected results never arrived", exp_result_q.size()));
        end
        else
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
